// File: testbench/freq_patterns.txt
# code half_ps gate_log2 thresh glitch, one test per line
# code 1 freq 2 gate change 3 diff stream 4 overrun 5 glitch 6 disabled, glitch 1 moves 0 still 2 n/a
1 4000 8 2 2
1 3000 8 2 2
1 3000 10 2 2
1 1500 10 2 2
2 3000 9 2 2
3 1500 8 2 2
3 4000 8 2 2
4 4000 7 2 2
5 500 8 2 1
5 4000 8 2 0
6 3000 8 2 2

// File: verilog.f
+incdir+hw
hw/freq_cfg_pkg.sv
hw/freq_meas_pkg.sv
hw/freq_cfg_if.sv
hw/freq_edge_sampler.sv
hw/freq_count.sv
hw/freq_cfg_regs.sv
hw/freq_meter_top.sv
testbench/freq_meter_properties.sv
testbench/tb_freq_meter.sv

// File: Makefile
# Verilator flow for the frequency meter testbench
VERILATOR ?= verilator
TOP       ?= tb_freq_meter
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_freq_meter.sv
//============================================================================
// frequency meter testbench, replays the pattern file against the top level
//============================================================================
`timescale 1ns/1ps

module tb_freq_meter import freq_cfg_pkg::*; ();

	localparam int    MAX_TESTS    = 32;
	localparam int    START_GATE   = 8;
	localparam string PATTERN_FILE = "testbench/freq_patterns.txt";

	logic        sysclk, arst_n, f_in;
	logic        cfg_valid, cfg_ready;
	cfg_op_e     cfg_op;
	logic [7:0]  cfg_data;
	logic        res_valid, res_ready;
	logic [27:0] frequency;
	logic [15:0] diff_stream;
	logic        diff_stream_strobe, glitch_catcher, overrun;

	// pattern table, one entry per line of the file
	int t_code [MAX_TESTS];
	int t_half [MAX_TESTS];
	int t_gate [MAX_TESTS];
	int t_thresh [MAX_TESTS];
	int t_glitch [MAX_TESTS];
	int n_tests;

	realtime f_half = 4.0;
	// res_ready source: 0 low, 1 high, 2 random
	int ready_mode;
	int seed = 32'h5674;
	int rnd;
	int cycle, limit, errors, checks;

	freq_meter_top dut (.*);

	bind freq_count freq_meter_properties u_props (.*);

	always #2 sysclk = ~sysclk;

	// f_in edges land in the NBA region, so sysclk flops see the old gray value
	always begin
		#(f_half);
		f_in <= ~f_in;
	end

	always @(posedge sysclk) begin
		rnd = $random(seed);
		case (ready_mode)
			0: res_ready <= 1'b0;
			1: res_ready <= 1'b1;
			default: res_ready <= rnd[0];
		endcase
	end

	// watchdog on the whole run
	always @(posedge sysclk) begin
		cycle <= cycle + 1;
		if (cycle > limit) begin
			$display("timeout: run still busy after %0d cycles", cycle);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input int expected, input int actual,
			input int tol);
		checks++;
		if (actual < expected - tol || actual > expected + tol) begin
			errors++;
			$display("ERR %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// edges in 2**gate cycles of 4 ns, rounded, for a period of 2*half_ps
	function automatic int expected_count(input int half_ps, input int gate);
		longint num;
		longint den;
		num = longint'(4000) << gate;
		den = 2 * half_ps;
		return int'((num + den / 2) / den);
	endfunction

	function automatic string code_name(input int code);
		case (code)
			1: return "freq";
			2: return "gate_change";
			3: return "diff_stream";
			4: return "overrun";
			5: return "glitch";
			6: return "disabled";
			default: return "unknown";
		endcase
	endfunction

	// one host write, ready drops for the settle cycle and comes back
	task automatic write_cfg(input string name, input cfg_op_e op, input int data,
			output int acc_cycle);
		cfg_valid <= 1'b1;
		cfg_op    <= op;
		cfg_data  <= data[7:0];
		do begin
			@(posedge sysclk);
		end while (!cfg_ready);
		acc_cycle = cycle;
		cfg_valid <= 1'b0;
		@(posedge sysclk);
		check_value({name, "_settle"}, 0, int'(cfg_ready), 0);
		@(posedge sysclk);
		check_value({name, "_ready"}, 1, int'(cfg_ready), 0);
	endtask

	task automatic wait_result(output int value);
		do begin
			@(posedge sysclk);
		end while (!(res_valid && res_ready));
		value = int'(frequency);
	endtask

	// stop counting, drain any result, retune f_in and let the pipeline settle
	task automatic prepare(input string name, input int idx, input int gate);
		int acc;
		ready_mode <= 1;
		write_cfg({name, "_disable"}, op_enable, 0, acc);
		f_half <= t_half[idx] / 1000.0;
		repeat (16) @(posedge sysclk);
		write_cfg({name, "_gate"}, op_set_gate, gate, acc);
		write_cfg({name, "_thresh"}, op_set_thresh, t_thresh[idx], acc);
	endtask

	task automatic run_test(input int idx);
		string name;
		int    acc, value, seen, last_strobe, changes, k, n, lo, hi, expect_f;
		logic  held, prev_glitch;
		name     = $sformatf("t%0d_%s", idx, code_name(t_code[idx]));
		expect_f = expected_count(t_half[idx], t_gate[idx]);
		case (t_code[idx])
			1: begin
				prepare(name, idx, t_gate[idx]);
				ready_mode <= 2;
				write_cfg(name, op_enable, 1, acc);
				// first gate after enable is complete, both results count
				repeat (2) begin
					wait_result(value);
					check_value(name, expect_f, value, 1);
				end
			end
			2: begin
				prepare(name, idx, START_GATE);
				ready_mode <= 2;
				write_cfg(name, op_enable, 1, acc);
				repeat (100) @(posedge sysclk);
				write_cfg(name, op_set_gate, t_gate[idx], acc);
				do begin
					@(posedge sysclk);
				end while (!res_valid);
				check_value({name, "_latency"}, 2 + (1 << t_gate[idx]), cycle - acc, 0);
				while (!res_ready) begin
					@(posedge sysclk);
				end
				check_value(name, expect_f, int'(frequency), 1);
			end
			3: begin
				prepare(name, idx, t_gate[idx]);
				// floor and ceiling of the edges in one 4 ns cycle
				lo          = 4000 / (2 * t_half[idx]);
				hi          = (4000 + 2 * t_half[idx] - 1) / (2 * t_half[idx]);
				last_strobe = -1;
				k           = 0;
				while (k < 8) begin
					@(posedge sysclk);
					if (diff_stream_strobe) begin
						if (last_strobe >= 0) begin
							check_value({name, "_spacing"}, 4, cycle - last_strobe, 0);
						end
						last_strobe = cycle;
						for (n = 0; n < 4; n++) begin
							// twice the nibble stays within hi - lo of lo + hi
							check_value({name, "_nibble_x2"}, lo + hi,
								2 * int'(diff_stream[4*n +: 4]), hi - lo);
						end
						k++;
					end
				end
			end
			4: begin
				prepare(name, idx, t_gate[idx]);
				write_cfg(name, op_clear_ovr, 0, acc);
				ready_mode <= 0;
				write_cfg(name, op_enable, 1, acc);
				held = 1'b0;
				// second gate end on an untaken result sets overrun
				do begin
					@(posedge sysclk);
					if (held) begin
						check_value({name, "_valid_held"}, 1, int'(res_valid), 0);
					end
					held = held | res_valid;
				end while (!overrun);
				check_value({name, "_valid"}, 1, int'(res_valid), 0);
				write_cfg(name, op_clear_ovr, 0, acc);
				ready_mode <= 1;
				wait_result(value);
				check_value(name, expect_f, value, 1);
				@(posedge sysclk);
				check_value({name, "_overrun"}, 0, int'(overrun), 0);
			end
			5: begin
				prepare(name, idx, t_gate[idx]);
				prev_glitch = glitch_catcher;
				changes     = 0;
				repeat (64) begin
					@(posedge sysclk);
					if (glitch_catcher != prev_glitch) begin
						changes++;
					end
					prev_glitch = glitch_catcher;
				end
				check_value({name, "_moved"}, t_glitch[idx], int'(changes > 0), 0);
			end
			6: begin
				// counting stays off from prepare
				prepare(name, idx, t_gate[idx]);
				seen = 0;
				repeat ((1 << t_gate[idx]) + 50) begin
					@(posedge sysclk);
					if (res_valid) begin
						seen++;
					end
				end
				check_value({name, "_no_result"}, 0, seen, 0);
			end
			default: begin
				errors++;
				$display("pattern line %0d has an unknown test code %0d", idx, t_code[idx]);
			end
		endcase
	endtask

	initial begin
		int    fd;
		string line;
		int    code, half, gate, thr, gl;
		sysclk     = 1'b0;
		arst_n     = 1'b0;
		f_in       = 1'b0;
		cfg_valid  = 1'b0;
		cfg_op     = op_set_gate;
		cfg_data   = '0;
		res_ready  = 1'b0;
		ready_mode = 1;
		errors     = 0;
		checks     = 0;
		cycle      = 0;
		n_tests    = 0;
		limit      = 200;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the pattern file %s", PATTERN_FILE);
		end else begin
			while (!$feof(fd) && n_tests < MAX_TESTS) begin
				line = "";
				if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
					if ($sscanf(line, "%d %d %d %d %d", code, half, gate, thr, gl) == 5) begin
						t_code[n_tests]   = code;
						t_half[n_tests]   = half;
						t_gate[n_tests]   = gate;
						t_thresh[n_tests] = thr;
						t_glitch[n_tests] = gl;
						// three gate lengths per test bound the run
						limit += 3 * (1 << gate);
						n_tests++;
					end
				end
			end
			$fclose(fd);
		end
		repeat (5) @(posedge sysclk);
		arst_n <= 1'b1;
		@(posedge sysclk);
		for (int i = 0; i < n_tests; i++) begin
			run_test(i);
		end
		// bound assertion failures add to the error count
		errors += dut.u_count.u_props.failures;
		$display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		if (errors == 0 && n_tests > 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/freq_meter_properties.sv
//============================================================================
// handshake and reset assertions, bound into the counter by the testbench
//============================================================================
`timescale 1ns/1ps

module freq_meter_properties import freq_meas_pkg::*; (
	input logic  sysclk,
	input logic  arst_n,
	input logic  res_valid,
	input logic  res_ready,
	input freq_t frequency,
	input logic  overrun,
	input logic  diff_stream_strobe,
	input logic  glitch_catcher
);

	// count of failed assertions
	int failures = 0;

	// a pending result only leaves through a transfer
	valid_held: assert property (@(posedge sysclk) disable iff (!arst_n)
		res_valid && !res_ready |=> res_valid)
		else begin
			$error("res_valid dropped without a transfer");
			failures++;
		end

	// held value only moves when a newer gate overwrites it
	freq_held: assert property (@(posedge sysclk) disable iff (!arst_n)
		res_valid && !res_ready |=> $stable(frequency) || overrun)
		else begin
			$error("frequency changed while waiting for res_ready");
			failures++;
		end

	// first sampled cycle out of reset
	reset_quiet: assert property (@(posedge sysclk)
		$rose(arst_n) |-> !res_valid && !overrun && !diff_stream_strobe && !glitch_catcher)
		else begin
			$error("outputs not quiet after reset release");
			failures++;
		end

endmodule

// File: hw/freq_meter_top.sv
//============================================================================
// frequency meter top level, plain ports for host config, result and diagnostics
//============================================================================
`timescale 1ns/1ps
`include "freq_macros.svh"

module freq_meter_top import freq_cfg_pkg::*, freq_meas_pkg::*; (
	input  logic                        sysclk,
	input  logic                        arst_n,
	input  logic                        f_in,
	// host configuration writes
	input  logic                        cfg_valid,
	output logic                        cfg_ready,
	input  cfg_op_e                     cfg_op,
	input  logic [`FREQ_CFG_DATA_W-1:0] cfg_data,
	// measurement result
	output logic                        res_valid,
	input  logic                        res_ready,
	output freq_t                       frequency,
	// diagnostics
	output diff_stream_t                diff_stream,
	output logic                        diff_stream_strobe,
	output logic                        glitch_catcher,
	output logic                        overrun
);

	xcount_t xcount;

	freq_cfg_if cfg_bus ();

	freq_edge_sampler u_sampler (
		.sysclk (sysclk),
		.arst_n (arst_n),
		.f_in   (f_in),
		.xcount (xcount)
	);

	freq_cfg_regs u_regs (
		.sysclk    (sysclk),
		.arst_n    (arst_n),
		.cfg_valid (cfg_valid),
		.cfg_ready (cfg_ready),
		.cfg_op    (cfg_op),
		.cfg_data  (cfg_data),
		.cfg       (cfg_bus.regs)
	);

	freq_count u_count (
		.sysclk             (sysclk),
		.arst_n             (arst_n),
		.xcount             (xcount),
		.cfg                (cfg_bus.counter),
		.res_ready          (res_ready),
		.res_valid          (res_valid),
		.frequency          (frequency),
		.overrun            (overrun),
		.diff_stream        (diff_stream),
		.diff_stream_strobe (diff_stream_strobe),
		.glitch_catcher     (glitch_catcher)
	);

endmodule

// File: hw/freq_cfg_regs.sv
//============================================================================
// host register block, decodes opcode writes into the configuration link
//============================================================================
`timescale 1ns/1ps
`include "freq_macros.svh"

module freq_cfg_regs import freq_cfg_pkg::*; (
	input  logic                        sysclk,
	input  logic                        arst_n,
	input  logic                        cfg_valid,
	output logic                        cfg_ready,
	input  cfg_op_e                     cfg_op,
	input  logic [`FREQ_CFG_DATA_W-1:0] cfg_data,
	freq_cfg_if.regs                    cfg
);

	function automatic logic [`FREQ_GATE_W-1:0] clamp_gate(
		input logic [`FREQ_CFG_DATA_W-1:0] d
	);
		if (d < `FREQ_GATE_LOG2_MIN) begin
			return `FREQ_GATE_W'(`FREQ_GATE_LOG2_MIN);
		end
		if (d > `FREQ_GATE_LOG2_MAX) begin
			return `FREQ_GATE_W'(`FREQ_GATE_LOG2_MAX);
		end
		return d[`FREQ_GATE_W-1:0];
	endfunction

	cfg_state_e              state;
	logic [`FREQ_GATE_W-1:0] gate_new;

	// settle during reset keeps ready low until the first clock after release
	assign cfg_ready = (state == st_idle);
	assign gate_new  = clamp_gate(cfg_data);

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			state             <= st_settle;
			cfg.gate_log2     <= `FREQ_GATE_W'(`FREQ_GATE_DEFAULT);
			cfg.glitch_thresh <= `FREQ_GW'(`FREQ_THRESH_DEFAULT);
			cfg.count_en      <= 1'b0;
			cfg.restart       <= 1'b0;
			cfg.ovr_clr       <= 1'b0;
		end else begin
			cfg.restart <= 1'b0;
			cfg.ovr_clr <= 1'b0;
			case (state)
				st_idle: begin
					if (cfg_valid) begin
						state <= st_settle;
						case (cfg_op)
							op_set_gate: begin
								cfg.gate_log2 <= gate_new;
								cfg.restart   <= (gate_new != cfg.gate_log2);
							end
							op_set_thresh: begin
								// anything past the nibble range saturates
								if (|cfg_data[`FREQ_CFG_DATA_W-1:`FREQ_GW]) begin
									cfg.glitch_thresh <= '1;
								end else begin
									cfg.glitch_thresh <= cfg_data[`FREQ_GW-1:0];
								end
							end
							op_enable: begin
								cfg.count_en <= cfg_data[0];
								cfg.restart  <= (cfg_data[0] != cfg.count_en);
							end
							default: cfg.ovr_clr <= 1'b1;
						endcase
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: hw/freq_count.sv
//============================================================================
// gate timer and accumulator, result hold with valid/ready, diagnostics
//============================================================================
`timescale 1ns/1ps
`include "freq_macros.svh"

module freq_count import freq_meas_pkg::*; (
	input  logic          sysclk,
	input  logic          arst_n,
	input  xcount_t       xcount,
	freq_cfg_if.counter   cfg,
	input  logic          res_ready,
	output logic          res_valid,
	output freq_t         frequency,
	output logic          overrun,
	output diff_stream_t  diff_stream,
	output logic          diff_stream_strobe,
	output logic          glitch_catcher
);

	localparam int REF_W = `FREQ_GATE_LOG2_MAX + 1;

	logic [REF_W-1:0] refcnt, refcnt_next;
	logic             gate_end;
	freq_t            accum, total;
	logic [1:0]       phase;
	diff_stream_t     stream;

	// carry into bit gate_log2 ends the gate, 2**gate_log2 cycles after restart
	assign refcnt_next = refcnt + REF_W'(1);
	assign gate_end    = cfg.count_en && !cfg.restart && refcnt_next[cfg.gate_log2];
	// the closing cycle's xcount belongs to this gate
	assign total       = accum + freq_t'(xcount);

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			refcnt <= '0;
			accum  <= '0;
		end else if (cfg.restart || !cfg.count_en || gate_end) begin
			refcnt <= '0;
			accum  <= '0;
		end else begin
			refcnt <= refcnt_next;
			accum  <= total;
		end
	end

	// result handshake, a new gate overwrites an untaken result
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
			overrun   <= 1'b0;
		end else begin
			if (gate_end) begin
				res_valid <= 1'b1;
			end else if (res_ready) begin
				res_valid <= 1'b0;
			end
			if (cfg.ovr_clr) begin
				overrun <= 1'b0;
			end
			// set wins over a clear in the same cycle
			if (gate_end && res_valid && !res_ready) begin
				overrun <= 1'b1;
			end
		end
	end

	always_ff @(posedge sysclk) begin
		if (gate_end) begin
			frequency <= total;
		end
	end

	// strobe phase and glitch catcher run free of the gate
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			phase              <= '0;
			diff_stream_strobe <= 1'b0;
			glitch_catcher     <= 1'b0;
		end else begin
			phase              <= phase + 2'd1;
			diff_stream_strobe <= (phase == 2'd3);
			if (xcount > cfg.glitch_thresh) begin
				glitch_catcher <= ~glitch_catcher;
			end
		end
	end

	// shift register of nibbles, published every fourth cycle with the strobe
	always_ff @(posedge sysclk) begin
		stream <= {stream[3*`FREQ_GW-1:0], xcount};
		if (phase == 2'd3) begin
			diff_stream <= {stream[3*`FREQ_GW-1:0], xcount};
		end
	end

endmodule

// File: hw/freq_edge_sampler.sv
//============================================================================
// counts f_in edges in gray code and turns them into edges per sysclk cycle
//============================================================================
`timescale 1ns/1ps
`include "freq_macros.svh"

module freq_edge_sampler import freq_meas_pkg::*; (
	input  logic    sysclk,
	input  logic    arst_n,
	input  logic    f_in,
	output xcount_t xcount
);

	function automatic logic [`FREQ_GW-1:0] bin2gray(input logic [`FREQ_GW-1:0] b);
		return b ^ (b >> 1);
	endfunction

	function automatic logic [`FREQ_GW-1:0] gray2bin(input logic [`FREQ_GW-1:0] g);
		logic [`FREQ_GW-1:0] b;
		b[`FREQ_GW-1] = g[`FREQ_GW-1];
		for (int i = `FREQ_GW - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	logic [`FREQ_GW-1:0] bin_f, bin_f_next, gray_f;
	logic [`FREQ_GW-1:0] sync1, sync2, bin_s, prev_bin;

	// f_in domain, gray value comes straight from a flop so only one bit moves per edge
	assign bin_f_next = bin_f + `FREQ_GW'(1);

	always_ff @(posedge f_in or negedge arst_n) begin
		if (!arst_n) begin
			bin_f  <= '0;
			gray_f <= '0;
		end else begin
			bin_f  <= bin_f_next;
			gray_f <= bin2gray(bin_f_next);
		end
	end

	// two flop synchronizer into sysclk, then back to binary
	assign bin_s = gray2bin(sync2);

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			sync1    <= '0;
			sync2    <= '0;
			prev_bin <= '0;
			xcount   <= '0;
		end else begin
			sync1    <= gray_f;
			sync2    <= sync1;
			prev_bin <= bin_s;
			// modulo difference, wraps with the counter
			xcount   <= bin_s - prev_bin;
		end
	end

endmodule

// File: hw/freq_cfg_if.sv
//============================================================================
// configuration link, register block drives it and the counter reads it
//============================================================================
`timescale 1ns/1ps
`include "freq_macros.svh"

interface freq_cfg_if import freq_meas_pkg::*; ();

	logic [`FREQ_GATE_W-1:0] gate_log2;
	xcount_t                 glitch_thresh;
	logic                    count_en;
	// one-cycle pulses
	logic                    restart;
	logic                    ovr_clr;

	modport regs (
		output gate_log2, glitch_thresh, count_en, restart, ovr_clr
	);

	modport counter (
		input gate_log2, glitch_thresh, count_en, restart, ovr_clr
	);

endinterface

// File: hw/freq_meas_pkg.sv
//============================================================================
// measurement types for the edge sampler, counter and top level
//============================================================================
`include "freq_macros.svh"

package freq_meas_pkg;

	// f_in edges seen in one sysclk cycle
	typedef logic [`FREQ_GW-1:0] xcount_t;

	// f_in edges summed over one gate
	typedef logic [`FREQ_WIDTH-1:0] freq_t;

	// last four xcount nibbles, newest in bits 3:0
	typedef logic [4*`FREQ_GW-1:0] diff_stream_t;

endpackage

// File: hw/freq_cfg_pkg.sv
//============================================================================
// configuration types shared by the register block and the top level ports
//============================================================================
package freq_cfg_pkg;

	// host opcodes, data word meaning depends on the op
	typedef enum logic [1:0] {
		op_set_gate   = 2'd0,
		op_set_thresh = 2'd1,
		op_enable     = 2'd2,
		op_clear_ovr  = 2'd3
	} cfg_op_e;

	// register block write state, one write per two cycles
	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_settle = 2'd1
	} cfg_state_e;

endpackage

// File: hw/freq_macros.svh
//============================================================================
// widths and limits of the frequency meter, included by RTL files that need them
//============================================================================
`ifndef FREQ_MACROS_SVH
`define FREQ_MACROS_SVH

// gray counter and per-cycle edge count width
`define FREQ_GW 4
// accumulated edges per gate
`define FREQ_WIDTH 28
// gate exponent range, gate length is 2**gate_log2 sysclk cycles
`define FREQ_GATE_LOG2_MIN 2
`define FREQ_GATE_LOG2_MAX 24
`define FREQ_GATE_W 5
// host configuration word and reset defaults
`define FREQ_CFG_DATA_W 8
`define FREQ_GATE_DEFAULT 8
`define FREQ_THRESH_DEFAULT 2
`endif
